/* Makefile */
TOP = csr_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

/* design/csr_pkg.sv */
package csr_pkg;

    typedef logic [13:0] csr_addr_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // CSR numbers
    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam csr_data_t CRMD_WMASK   = 32'h0000_01ff; // PLV, IE, DA, PG, DATF, DATM
    localparam csr_data_t PRMD_WMASK   = 32'h0000_0007; // PPLV, PIE
    localparam csr_data_t ECFG_WMASK   = 32'h0000_1bff; // LIE without bit 10
    localparam csr_data_t ESTAT_WMASK  = 32'h0000_0003; // Software interrupts
    localparam csr_data_t EENTRY_WMASK = 32'hffff_ffc0;

    localparam csr_data_t CRMD_RESET = 32'h0000_0008; // DA set

    localparam int TIMER_IRQ_BIT = 11;

    // Write-back commit
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wr_t;

    typedef struct packed {
        logic         exception;
        logic         ertn;
        ecode_t       ecode;
        esubcode_t    esubcode;
        logic [30:0]  pc;       // Bit 0 implied zero
    } exc_event_t;

    // Values seen by the control stage
    typedef struct packed {
        csr_data_t crmd;
        csr_data_t era;
        csr_data_t eentry;
    } ctrl_view_t;

    typedef enum logic [1:0] {
        TIMER_STOPPED,
        TIMER_ONE_SHOT,
        TIMER_PERIODIC
    } timer_state_t;

endpackage

/* design/csr_read_mux.sv */
`timescale 1ns/1ns

module csr_read_mux (
    input  logic               rd_en,
    input  csr_pkg::csr_addr_t rd_addr,
    input  csr_pkg::csr_data_t crmd,
    input  csr_pkg::csr_data_t prmd,
    input  csr_pkg::csr_data_t ecfg,
    input  csr_pkg::csr_data_t estat,
    input  csr_pkg::csr_data_t era,
    input  csr_pkg::csr_data_t eentry,
    input  csr_pkg::csr_data_t save0,
    input  csr_pkg::csr_data_t save1,
    input  csr_pkg::csr_data_t save2,
    input  csr_pkg::csr_data_t save3,
    input  csr_pkg::csr_data_t tid,
    input  csr_pkg::csr_data_t tcfg,
    input  csr_pkg::csr_data_t tval,
    output csr_pkg::csr_data_t rd_data
);

    always_comb begin
        rd_data = '0;
        if (rd_en) begin
            case (rd_addr)
                csr_pkg::CSR_CRMD:   rd_data = crmd;
                csr_pkg::CSR_PRMD:   rd_data = prmd;
                csr_pkg::CSR_ECFG:   rd_data = ecfg;
                csr_pkg::CSR_ESTAT:  rd_data = estat;
                csr_pkg::CSR_ERA:    rd_data = era;
                csr_pkg::CSR_EENTRY: rd_data = eentry;
                csr_pkg::CSR_SAVE0:  rd_data = save0;
                csr_pkg::CSR_SAVE1:  rd_data = save1;
                csr_pkg::CSR_SAVE2:  rd_data = save2;
                csr_pkg::CSR_SAVE3:  rd_data = save3;
                csr_pkg::CSR_TID:    rd_data = tid;
                csr_pkg::CSR_TCFG:   rd_data = tcfg;
                csr_pkg::CSR_TVAL:   rd_data = tval;
                csr_pkg::CSR_TICLR:  rd_data = '0; // Write-only clear
                default:             rd_data = '0;
            endcase
        end
    end
endmodule

/* design/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_wr_t    csr_wr,
    input  csr_pkg::exc_event_t exc,
    input  logic [7:0]          hw_int,
    input  logic                rd_en,
    input  csr_pkg::csr_addr_t  rd_addr,
    output csr_pkg::csr_data_t  rd_data,
    output csr_pkg::ctrl_view_t ctrl,
    output logic                intr_req
);

    localparam int timer_width = 32;

    csr_pkg::csr_data_t crmd, prmd, ecfg, estat, era, eentry;
    csr_pkg::csr_data_t save0, save1, save2, save3, tid;
    csr_pkg::csr_data_t tcfg, tval;

    logic load;
    logic running;
    logic fire;
    logic reload_init;
    logic zero;

    exc_state_regs i_exc_state_regs (
        .clk, .rst, .csr_wr, .exc, .hw_int, .fire,
        .crmd, .prmd, .ecfg, .estat, .era, .eentry,
        .intr_req
    );

    timer_fsm i_timer_fsm (
        .clk, .rst, .csr_wr, .zero,
        .load, .running, .fire, .reload_init
    );

    // Counter sees the TCFG word only through load
    timer_counter #(.timer_width(timer_width)) i_timer_counter (
        .clk, .rst, .load,
        .load_word (csr_wr.data),
        .running, .fire, .reload_init,
        .tcfg, .tval, .zero
    );

    scratch_regs i_scratch_regs (
        .clk, .rst, .csr_wr,
        .save0, .save1, .save2, .save3, .tid
    );

    csr_read_mux i_csr_read_mux (
        .rd_en, .rd_addr,
        .crmd, .prmd, .ecfg, .estat, .era, .eentry,
        .save0, .save1, .save2, .save3, .tid,
        .tcfg, .tval,
        .rd_data
    );

    assign ctrl.crmd   = crmd;
    assign ctrl.era    = era;
    assign ctrl.eentry = eentry;
endmodule

/* design/exc_state_regs.sv */
`timescale 1ns/1ns

module exc_state_regs (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_wr_t    csr_wr,
    input  csr_pkg::exc_event_t exc,
    input  logic [7:0]          hw_int,
    input  logic                fire,
    output csr_pkg::csr_data_t  crmd,
    output csr_pkg::csr_data_t  prmd,
    output csr_pkg::csr_data_t  ecfg,
    output csr_pkg::csr_data_t  estat,
    output csr_pkg::csr_data_t  era,
    output csr_pkg::csr_data_t  eentry,
    output logic                intr_req
);

    function automatic csr_pkg::csr_data_t masked(input csr_pkg::csr_data_t old_val,
                                                  input csr_pkg::csr_data_t new_val,
                                                  input csr_pkg::csr_data_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

    logic               wr_ok;
    logic               ticlr_clr;
    csr_pkg::csr_data_t estat_wr;

    // Exception and ertn both block a commit in the same cycle
    assign wr_ok     = csr_wr.en && !exc.exception && !exc.ertn;
    assign ticlr_clr = wr_ok && csr_wr.addr == csr_pkg::CSR_TICLR && csr_wr.data[0];
    assign estat_wr  = masked(estat, csr_wr.data, csr_pkg::ESTAT_WMASK);

    always_ff @(posedge clk) begin
        if (rst) begin
            crmd <= csr_pkg::CRMD_RESET;
        end else if (exc.exception) begin
            crmd[2:0] <= 3'b000; // PLV0, IE off
        end else if (exc.ertn) begin
            crmd[2:0] <= prmd[2:0];
        end else if (wr_ok && csr_wr.addr == csr_pkg::CSR_CRMD) begin
            crmd <= masked(crmd, csr_wr.data, csr_pkg::CRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd <= '0;
        end else if (exc.exception) begin
            prmd[2:0] <= crmd[2:0]; // Save PLV and IE
        end else if (wr_ok && csr_wr.addr == csr_pkg::CSR_PRMD) begin
            prmd <= masked(prmd, csr_wr.data, csr_pkg::PRMD_WMASK);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg   <= '0;
            eentry <= '0;
        end else if (wr_ok) begin
            if (csr_wr.addr == csr_pkg::CSR_ECFG) begin
                ecfg <= masked(ecfg, csr_wr.data, csr_pkg::ECFG_WMASK);
            end
            if (csr_wr.addr == csr_pkg::CSR_EENTRY) begin
                eentry <= masked(eentry, csr_wr.data, csr_pkg::EENTRY_WMASK);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            era <= '0;
        end else if (exc.exception) begin
            era <= {exc.pc, 1'b0};
        end else if (wr_ok && csr_wr.addr == csr_pkg::CSR_ERA) begin
            era <= csr_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            estat <= '0;
        end else begin
            estat[9:2] <= hw_int;
            if (ticlr_clr) begin
                estat[csr_pkg::TIMER_IRQ_BIT] <= 1'b0; // Clear beats a new fire
            end else if (fire) begin
                estat[csr_pkg::TIMER_IRQ_BIT] <= 1'b1;
            end
            if (exc.exception) begin
                estat[21:16] <= exc.ecode;
                estat[30:22] <= exc.esubcode;
            end else if (wr_ok && csr_wr.addr == csr_pkg::CSR_ESTAT) begin
                estat[1:0] <= estat_wr[1:0];
            end
        end
    end

    assign intr_req = crmd[2] && |(estat[12:0] & ecfg[12:0]);

endmodule

/* design/scratch_regs.sv */
`timescale 1ns/1ns

module scratch_regs (
    input  logic               clk,
    input  logic               rst,
    input  csr_pkg::csr_wr_t   csr_wr,
    output csr_pkg::csr_data_t save0,
    output csr_pkg::csr_data_t save1,
    output csr_pkg::csr_data_t save2,
    output csr_pkg::csr_data_t save3,
    output csr_pkg::csr_data_t tid
);

    localparam csr_pkg::csr_addr_t ADDRS [5] = '{csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
                                                 csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3,
                                                 csr_pkg::CSR_TID};

    csr_pkg::csr_data_t regs [5];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 5; i++) begin
            if (rst) begin
                regs[i] <= '0;
            end else if (csr_wr.en && csr_wr.addr == ADDRS[i]) begin
                regs[i] <= csr_wr.data; // All bits writable
            end
        end
    end

    assign save0 = regs[0];
    assign save1 = regs[1];
    assign save2 = regs[2];
    assign save3 = regs[3];
    assign tid   = regs[4];
endmodule

/* design/timer_counter.sv */
`timescale 1ns/1ns

module timer_counter #(
    parameter int timer_width = 32
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               load,
    input  csr_pkg::csr_data_t load_word,
    input  logic               running,
    input  logic               fire,
    input  logic               reload_init,
    output csr_pkg::csr_data_t tcfg,
    output csr_pkg::csr_data_t tval,
    output logic               zero
);

    logic [timer_width-1:0] cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            tcfg <= '0;
            cnt  <= '0;
        end else if (load) begin
            tcfg <= load_word;
            cnt  <= {load_word[timer_width-1:2], 2'b00};
        end else if (fire) begin
            // Periodic goes back to the initial value, one-shot parks at all ones
            cnt <= reload_init ? {tcfg[timer_width-1:2], 2'b00} : '1;
        end else if (running && !zero) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign zero = cnt == '0;
    assign tval = csr_pkg::csr_data_t'(cnt); // Zero-extended
endmodule

/* design/timer_fsm.sv */
`timescale 1ns/1ns

module timer_fsm (
    input  logic             clk,
    input  logic             rst,
    input  csr_pkg::csr_wr_t csr_wr,
    input  logic             zero,
    output logic             load,
    output logic             running,
    output logic             fire,
    output logic             reload_init
);

    csr_pkg::timer_state_t state;
    csr_pkg::timer_state_t state_nxt;

    assign load = csr_wr.en && csr_wr.addr == csr_pkg::CSR_TCFG;

    always_comb begin
        state_nxt = state;
        if (load) begin
            if (!csr_wr.data[0]) begin
                state_nxt = csr_pkg::TIMER_STOPPED;
            end else if (csr_wr.data[1]) begin
                state_nxt = csr_pkg::TIMER_PERIODIC;
            end else begin
                state_nxt = csr_pkg::TIMER_ONE_SHOT;
            end
        end else if (fire && state == csr_pkg::TIMER_ONE_SHOT) begin
            state_nxt = csr_pkg::TIMER_STOPPED;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= csr_pkg::TIMER_STOPPED;
        end else begin
            state <= state_nxt;
        end
    end

    assign running     = state != csr_pkg::TIMER_STOPPED;
    assign fire        = running && zero;
    assign reload_init = fire && state == csr_pkg::TIMER_PERIODIC; // Periodic restarts at I
endmodule

/* sources.f */
design/csr_pkg.sv
design/exc_state_regs.sv
design/timer_fsm.sv
design/timer_counter.sv
design/scratch_regs.sv
design/csr_read_mux.sv
design/csr_unit.sv
verif/csr_unit_chk.sv
verif/csr_unit_tb.sv

/* verif/csr_unit_chk.sv */
`timescale 1ns/1ns

module csr_unit_chk (
    input logic               clk,
    input logic               rst,
    input logic               rd_en,
    input csr_pkg::csr_data_t rd_data,
    input logic               intr_req,
    input logic [7:0]         hw_int,
    input logic               fire,
    input logic               reload_init,
    input csr_pkg::csr_data_t crmd,
    input csr_pkg::csr_data_t ecfg,
    input csr_pkg::csr_data_t estat
);

    int fails = 0;

    // Reset cycles and the first cycle after release
    intr_quiet_in_reset: assert property (@(posedge clk) $past(rst) |-> !intr_req)
        else begin
            $error("intr_req set during reset or in the cycle after it");
            fails++;
        end

    fire_single_cycle: assert property (@(posedge clk) disable iff (rst)
        fire && !reload_init |=> !fire)
        else begin
            $error("timer fire held for more than one cycle outside periodic mode");
            fails++;
        end

    rd_data_idle_zero: assert property (@(posedge clk) !rd_en |-> rd_data == '0)
        else begin
            $error("rd_data not zero while rd_en is low");
            fails++;
        end

    // Hardware lines taken from hw_int one edge back
    intr_req_rule: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> intr_req == (crmd[2] &&
            |({estat[12:10], $past(hw_int), estat[1:0]} & ecfg[12:0])))
        else begin
            $error("intr_req does not match CRMD.IE and the enabled pending bits");
            fails++;
        end
endmodule

bind csr_unit csr_unit_chk i_chk (
    .clk, .rst, .rd_en, .rd_data, .intr_req, .hw_int,
    .fire, .reload_init, .crmd, .ecfg, .estat
);

/* verif/csr_unit_tb.sv */
`timescale 1ns/1ns

module csr_unit_tb;

    localparam int TIMEOUT_CYCLES = 2000; // Tests need about 200 cycles

    logic                clk = 1'b0;
    logic                rst;
    csr_pkg::csr_wr_t    csr_wr;
    csr_pkg::exc_event_t exc;
    logic [7:0]          hw_int;
    logic                rd_en;
    csr_pkg::csr_addr_t  rd_addr;
    csr_pkg::csr_data_t  rd_data;
    csr_pkg::ctrl_view_t ctrl;
    logic                intr_req;

    string test_name;
    int    checks = 0;
    int    errors = 0;
    int    test_errors;
    int    tests_passed = 0;
    int    tests_failed = 0;

    csr_unit i_csr_unit (.*);

    always #5 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input csr_pkg::csr_data_t expected,
                               input csr_pkg::csr_data_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
        csr_wr = {1'b1, addr, data};
        step(); // Sampled at this edge
        csr_wr.en = 1'b0;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
        rd_en   = 1'b1;
        rd_addr = addr;
        @(negedge clk);
        data = rd_data;
        step();
        rd_en = 1'b0;
    endtask

    task automatic expect_csr(input string what, input csr_pkg::csr_addr_t addr,
                              input csr_pkg::csr_data_t expected);
        csr_pkg::csr_data_t got;
        read_csr(addr, got);
        check_value(what, expected, got);
    endtask

    // k counts edges since the TCFG write edge N
    task automatic watch_timer_bit(input int k_first, input int k_last, input int set_at);
        rd_en   = 1'b1;
        rd_addr = csr_pkg::CSR_ESTAT;
        for (int k = k_first; k <= k_last; k++) begin
            @(negedge clk);
            check_value($sformatf("timer bit after edge N+%0d", k), 32'(k >= set_at),
                        32'(rd_data[csr_pkg::TIMER_IRQ_BIT]));
            step();
        end
        rd_en = 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        if (errors == test_errors) begin
            tests_passed++;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - test_errors);
        end
    endtask

    initial begin
        csr_pkg::csr_addr_t  addrs [10];
        csr_pkg::csr_data_t  masks [10];
        csr_pkg::csr_data_t  data;
        csr_pkg::exc_event_t ev;
        logic [2:0]          old_plv_ie;
        int                  chk_fails;

        rst     = 1'b1;
        csr_wr  = '0;
        exc     = '0;
        hw_int  = '0;
        rd_en   = 1'b0;
        rd_addr = '0;
        void'($urandom(36));
        addrs = '{csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
                  csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_CRMD,
                  csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
                  csr_pkg::CSR_EENTRY};
        masks = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
                  32'hffff_ffff, csr_pkg::CRMD_WMASK, csr_pkg::PRMD_WMASK,
                  csr_pkg::ECFG_WMASK, csr_pkg::ESTAT_WMASK, csr_pkg::EENTRY_WMASK};
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        begin_test("reset_values");
        for (int i = 0; i < 10; i++) begin
            expect_csr($sformatf("csr %h", addrs[i]), addrs[i],
                       addrs[i] == csr_pkg::CSR_CRMD ? csr_pkg::CRMD_RESET : '0);
        end
        expect_csr("era", csr_pkg::CSR_ERA, '0);
        expect_csr("tcfg", csr_pkg::CSR_TCFG, '0);
        expect_csr("tval", csr_pkg::CSR_TVAL, '0);
        check_value("intr_req", '0, 32'(intr_req));
        finish_test();

        begin_test("masked_writes");
        for (int i = 0; i < 10; i++) begin
            data = $urandom();
            write_csr(addrs[i], data);
            expect_csr($sformatf("csr %h", addrs[i]), addrs[i], data & masks[i]);
        end
        check_value("ctrl.eentry", data & csr_pkg::EENTRY_WMASK, ctrl.eentry); // Last write
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        expect_csr("ticlr", csr_pkg::CSR_TICLR, '0);
        expect_csr("unknown address", 14'h3ff, '0);
        finish_test();

        begin_test("exception_entry_ertn");
        old_plv_ie = 3'($urandom());
        write_csr(csr_pkg::CSR_CRMD, csr_pkg::CRMD_RESET | 32'(old_plv_ie));
        ev           = '0;
        ev.exception = 1'b1;
        ev.ecode     = 6'($urandom());
        ev.esubcode  = 9'($urandom());
        ev.pc        = 31'($urandom());
        exc = ev;
        step();
        exc = '0;
        expect_csr("prmd", csr_pkg::CSR_PRMD, 32'(old_plv_ie));
        expect_csr("crmd", csr_pkg::CSR_CRMD, csr_pkg::CRMD_RESET);
        check_value("ctrl.crmd", csr_pkg::CRMD_RESET, ctrl.crmd);
        expect_csr("era", csr_pkg::CSR_ERA, {ev.pc, 1'b0});
        check_value("ctrl.era", {ev.pc, 1'b0}, ctrl.era);
        read_csr(csr_pkg::CSR_ESTAT, data);
        check_value("estat ecode", 32'(ev.ecode), 32'(data[21:16]));
        check_value("estat esubcode", 32'(ev.esubcode), 32'(data[30:22]));
        exc.ertn = 1'b1;
        step();
        exc.ertn = 1'b0;
        expect_csr("crmd after ertn", csr_pkg::CSR_CRMD, csr_pkg::CRMD_RESET | 32'(old_plv_ie));
        finish_test();

        begin_test("one_shot_timer");
        write_csr(csr_pkg::CSR_TCFG, 32'd20 | 32'h1);
        watch_timer_bit(0, 24, 21);
        expect_csr("tval after fire", csr_pkg::CSR_TVAL, 32'hffff_ffff);
        repeat (5) step();
        expect_csr("tval parked", csr_pkg::CSR_TVAL, 32'hffff_ffff);
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        read_csr(csr_pkg::CSR_ESTAT, data);
        check_value("timer bit after ticlr", '0, 32'(data[csr_pkg::TIMER_IRQ_BIT]));
        finish_test();

        begin_test("periodic_timer");
        write_csr(csr_pkg::CSR_TCFG, 32'd8 | 32'h3);
        watch_timer_bit(0, 9, 9);
        write_csr(csr_pkg::CSR_TICLR, 32'h1); // Clears at edge N+11
        watch_timer_bit(11, 20, 18);
        write_csr(csr_pkg::CSR_TCFG, '0);
        write_csr(csr_pkg::CSR_TICLR, 32'h1);
        finish_test();

        begin_test("interrupt_request");
        write_csr(csr_pkg::CSR_ESTAT, '0);
        write_csr(csr_pkg::CSR_ECFG, 32'h4); // hw_int[0] lands in ESTAT bit 2
        write_csr(csr_pkg::CSR_CRMD, csr_pkg::CRMD_RESET | 32'h4);
        check_value("intr_req idle", '0, 32'(intr_req));
        hw_int = 8'h01;
        step();
        check_value("intr_req with IE", 32'h1, 32'(intr_req));
        write_csr(csr_pkg::CSR_CRMD, csr_pkg::CRMD_RESET);
        check_value("intr_req without IE", '0, 32'(intr_req));
        hw_int = '0;
        finish_test();

        chk_fails = i_csr_unit.i_chk.fails;
        $display("tests passed %0d failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, checks, errors, chk_fails);
        if (errors == 0 && tests_failed == 0 && chk_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end
endmodule
